// ==== Bender.yml ====
package:
  name: cdd_link

sources:
  - include_dirs:
      - include
    files:
      - src/cdd_pkg.sv
      - src/cdd_status_capture.sv
      - src/cdd_frame_buffer.sv
      - src/cdd_serial_link.sv
      - src/cdd_link.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/cdd_link_properties.sv
      - testbench/cdd_link_checker.sv
      - testbench/tb_cdd_link.sv

// ==== include/cdd_defs.svh ====
// Frame size, buffer depth, link timing and tallied command codes for the drive link
`ifndef CDD_DEFS_SVH
`define CDD_DEFS_SVH

// Bytes in one status or command frame
`define CDD_FRAME_BYTES 12

// Frames the buffer holds, equal to the producer's starting credits
`define CDD_FIFO_DEPTH 2

// Cycles from a pop to the first request of a frame
`define CDD_START_DELAY 16

// Cycles from the end of a byte to the next request
`define CDD_BYTE_GAP 24

// Command codes counted into bytes 9 and 8
`define CDD_TALLY_CODE_0 8'h06
`define CDD_TALLY_CODE_1 8'h09

`endif

// ==== src/cdd_frame_buffer.sv ====
// Small frame FIFO between status producer and serial link, pops turn into credits
`timescale 1ns/1ps
`default_nettype none

`include "cdd_defs.svh"

module cdd_frame_buffer (
	input  logic                clk_sys,
	input  logic                reset,
	input  logic                push,
	input  cdd_pkg::cdd_frame_u push_frame,
	input  logic                pop,
	output logic                pop_valid,
	output cdd_pkg::cdd_frame_u pop_frame,
	output logic                credit_return
);
	import cdd_pkg::*;

	localparam int depth   = `CDD_FIFO_DEPTH;
	localparam int ptr_w   = (depth > 1) ? $clog2(depth) : 1;
	localparam int count_w = $clog2(depth + 1);

	cdd_frame_u         mem [depth];
	logic [ptr_w-1:0]   wr_ptr;
	logic [ptr_w-1:0]   rd_ptr;
	logic [count_w-1:0] count;

	function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
		if (ptr == ptr_w'(depth - 1))
			return '0;
		return ptr + ptr_w'(1);
	endfunction

	assign pop_valid     = count != '0;
	assign pop_frame     = mem[rd_ptr];
	assign credit_return = pop && pop_valid;

	// No full flag, the producer never holds more credits than slots
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (credit_return)
				rd_ptr <= next_ptr(rd_ptr);
			case ({push, credit_return})
				2'b10:   count <= count + count_w'(1);
				2'b01:   count <= count - count_w'(1);
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (push)
			mem[wr_ptr] <= push_frame;
	end

endmodule

`default_nettype wire

// ==== src/cdd_link.sv ====
// Top level of the drive link, status producer into frame buffer into serial link
`timescale 1ns/1ps
`default_nettype none

module cdd_link (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  cdd_pkg::cdd_stat_in_t stat,
	input  cdd_pkg::cdd_host_rx_t host_rx,
	output cdd_pkg::cdd_host_tx_t host_tx,
	output cdd_pkg::cdd_cmd_out_t cmd
);
	import cdd_pkg::*;

	logic       push;
	cdd_frame_u push_frame;
	logic       credit_return;
	logic       pop;
	logic       pop_valid;
	cdd_frame_u pop_frame;

	cdd_status_capture cdd_status_capture_inst (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.stat          (stat),
		.credit_return (credit_return),
		.push          (push),
		.push_frame    (push_frame)
	);

	cdd_frame_buffer cdd_frame_buffer_inst (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.push          (push),
		.push_frame    (push_frame),
		.pop           (pop),
		.pop_valid     (pop_valid),
		.pop_frame     (pop_frame),
		.credit_return (credit_return)
	);

	cdd_serial_link cdd_serial_link_inst (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.pop_valid (pop_valid),
		.pop_frame (pop_frame),
		.pop       (pop),
		.host_rx   (host_rx),
		.host_tx   (host_tx),
		.cmd       (cmd)
	);

endmodule

`default_nettype wire

// ==== src/cdd_pkg.sv ====
// Frame and link bundle types, imported by every block of the drive link
`default_nettype none

`include "cdd_defs.svh"

package cdd_pkg;

	// Field view of a frame, top byte first
	typedef struct packed {
		logic [15:0] tail;
		logic [7:0]  tally_0;
		logic [7:0]  tally_1;
		logic [55:0] params;
		logic [7:0]  code;
	} cdd_frame_fields_t;

	// Byte view for the shifters, field view for tallies
	typedef union packed {
		logic [`CDD_FRAME_BYTES-1:0][7:0] bytes;
		cdd_frame_fields_t                fields;
	} cdd_frame_u;

	// Status frame posted by the emulator, new on every toggle change
	typedef struct packed {
		logic       toggle;
		cdd_frame_u frame;
	} cdd_stat_in_t;

	// Command frame returned to the emulator
	typedef struct packed {
		logic       toggle;
		cdd_frame_u frame;
	} cdd_cmd_out_t;

	// Host side of the serial channel
	typedef struct packed {
		logic comclk;
		logic hdata;
	} cdd_host_rx_t;

	// Drive side of the serial channel
	typedef struct packed {
		logic cdata;
		logic comreq_n;
		logic comsync_n;
	} cdd_host_tx_t;

endpackage

`default_nettype wire

// ==== src/cdd_serial_link.sv ====
// Drive side of the serial command channel, swaps one status frame for one command frame
`timescale 1ns/1ps
`default_nettype none

`include "cdd_defs.svh"

module cdd_serial_link (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  pop_valid,
	input  cdd_pkg::cdd_frame_u   pop_frame,
	output logic                  pop,
	input  cdd_pkg::cdd_host_rx_t host_rx,
	output cdd_pkg::cdd_host_tx_t host_tx,
	output cdd_pkg::cdd_cmd_out_t cmd
);
	import cdd_pkg::*;

	localparam int byte_w    = $clog2(`CDD_FRAME_BYTES);
	localparam int last_byte = `CDD_FRAME_BYTES - 1;
	localparam int timer_max =
		(`CDD_BYTE_GAP > `CDD_START_DELAY) ? `CDD_BYTE_GAP : `CDD_START_DELAY;
	localparam int timer_w   = $clog2(timer_max + 1);

	typedef enum logic [1:0] {
		st_idle,
		st_start,
		st_xfer,
		st_gap
	} state_t;

	state_t             state;
	logic               comclk_old;
	logic               comclk_fall;
	logic               comclk_rise;
	logic               bit_out;
	logic               bit_in;
	logic               byte_done;
	logic               frame_done;
	logic               timer_done;
	logic               start_go;
	logic [2:0]         bit_cnt;
	logic [byte_w-1:0]  byte_cnt;
	logic [timer_w-1:0] timer;
	logic [7:0]         out_shift;
	logic [7:0]         in_shift;
	logic [7:0]         rx_byte;
	logic               cdata;
	logic               comreq_n;
	logic               comsync_n;
	logic [7:0]         tally_0;
	logic [7:0]         tally_1;
	logic               cmd_toggle;
	cdd_frame_u         stat_frame;
	cdd_frame_u         cmd_frame;
	cdd_frame_u         cmd_final;
	cdd_frame_u         cmd_frame_q;

	////////////////////
	// Edges and strobes
	////////////////////

	assign comclk_fall = comclk_old && !host_rx.comclk;
	assign comclk_rise = !comclk_old && host_rx.comclk;

	assign bit_out    = (state == st_xfer) && comclk_fall;
	assign bit_in     = (state == st_xfer) && comclk_rise;
	assign byte_done  = bit_in && (bit_cnt == 3'd7);
	assign frame_done = byte_done && (byte_cnt == byte_w'(last_byte));
	assign timer_done = timer == timer_w'(1);
	assign start_go   = (state == st_start) && timer_done;

	// Host data arrives lsb first
	assign rx_byte = {host_rx.hdata, in_shift[7:1]};

	assign pop = (state == st_idle) && pop_valid;

	// Final byte plus tallies in place of bytes 9 and 8
	always_comb begin
		cmd_final                      = cmd_frame;
		cmd_final.bytes[last_byte]     = rx_byte;
		cmd_final.fields.tally_0       = tally_0;
		cmd_final.fields.tally_1       = tally_1;
	end

	////////////////////
	// Transaction FSM
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state      <= st_idle;
			comclk_old <= 1'b1;
			cdata      <= 1'b0;
			comreq_n   <= 1'b1;
			comsync_n  <= 1'b1;
			bit_cnt    <= '0;
			byte_cnt   <= '0;
			timer      <= '0;
			tally_0    <= '0;
			tally_1    <= '0;
			cmd_toggle <= 1'b0;
		end else begin
			comclk_old <= host_rx.comclk;
			if (timer != '0)
				timer <= timer - timer_w'(1);

			case (state)
				st_idle: begin
					if (pop) begin
						timer <= timer_w'(`CDD_START_DELAY - 1);
						state <= st_start;
					end
				end

				// Request and sync drop together for byte 0
				st_start: begin
					if (timer_done) begin
						comreq_n  <= 1'b0;
						comsync_n <= 1'b0;
						bit_cnt   <= '0;
						byte_cnt  <= '0;
						state     <= st_xfer;
					end
				end

				st_gap: begin
					if (timer_done) begin
						comreq_n <= 1'b0;
						state    <= st_xfer;
					end
				end

				st_xfer: begin
					if (bit_out)
						cdata <= out_shift[0];
					if (bit_in) begin
						comreq_n <= 1'b1;
						bit_cnt  <= bit_cnt + 3'd1;
					end
					if (byte_done) begin
						comsync_n <= 1'b1;
						byte_cnt  <= byte_cnt + byte_w'(1);
						timer     <= timer_w'(`CDD_BYTE_GAP - 1);
						state     <= st_gap;
					end
					// Publish, then count this command for later frames
					if (frame_done) begin
						cdata      <= 1'b0;
						byte_cnt   <= '0;
						timer      <= '0;
						cmd_toggle <= ~cmd_toggle;
						if (cmd_final.fields.code == `CDD_TALLY_CODE_0)
							tally_0 <= tally_0 + 8'd1;
						if (cmd_final.fields.code == `CDD_TALLY_CODE_1)
							tally_1 <= tally_1 + 8'd1;
						state      <= st_idle;
					end
				end

				default: state <= st_idle;
			endcase
		end
	end

	////////////////////
	// Data path
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (pop)
			stat_frame <= pop_frame;

		if (start_go)
			out_shift <= stat_frame.bytes[0];
		else if (bit_out)
			out_shift <= {1'b0, out_shift[7:1]};
		else if (byte_done && !frame_done)
			out_shift <= stat_frame.bytes[byte_cnt + byte_w'(1)];

		if (bit_in)
			in_shift <= rx_byte;
		if (byte_done)
			cmd_frame.bytes[byte_cnt] <= rx_byte;
		if (frame_done)
			cmd_frame_q <= cmd_final;
	end

	assign host_tx = '{cdata: cdata, comreq_n: comreq_n, comsync_n: comsync_n};
	assign cmd     = '{toggle: cmd_toggle, frame: cmd_frame_q};

endmodule

`default_nettype wire

// ==== src/cdd_status_capture.sv ====
// Status producer, spots new frames from the emulator and pushes them into the frame buffer
`timescale 1ns/1ps
`default_nettype none

`include "cdd_defs.svh"

module cdd_status_capture (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  cdd_pkg::cdd_stat_in_t stat,
	input  logic                  credit_return,
	output logic                  push,
	output cdd_pkg::cdd_frame_u   push_frame
);
	import cdd_pkg::*;

	localparam int credit_w = $clog2(`CDD_FIFO_DEPTH + 1);

	logic                toggle_q;
	logic                toggle_prev;
	cdd_frame_u          frame_q;
	logic                new_frame;
	logic                have_credit;
	logic                park;
	logic                pending_valid;
	cdd_frame_u          pending_frame;
	logic [credit_w-1:0] credits;

	assign new_frame   = toggle_q != toggle_prev;
	assign have_credit = credits != '0;

	// Older pending frame goes first, the new one parks behind it
	assign park       = new_frame && (pending_valid || !have_credit);
	assign push       = have_credit && (pending_valid || new_frame);
	assign push_frame = pending_valid ? pending_frame : frame_q;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			toggle_q      <= 1'b0;
			toggle_prev   <= 1'b0;
			pending_valid <= 1'b0;
			credits       <= credit_w'(`CDD_FIFO_DEPTH);
		end else begin
			toggle_q    <= stat.toggle;
			toggle_prev <= toggle_q;

			if (park)
				pending_valid <= 1'b1;
			else if (push)
				pending_valid <= 1'b0;

			case ({push, credit_return})
				2'b10:   credits <= credits - credit_w'(1);
				2'b01:   credits <= credits + credit_w'(1);
				default: credits <= credits;
			endcase
		end
	end

	// Newest status overwrites whatever waits in the slot
	always_ff @(posedge clk_sys) begin
		frame_q <= stat.frame;
		if (park)
			pending_frame <= frame_q;
	end

endmodule

`default_nettype wire

// ==== testbench/cdd_link_checker.sv ====
// Scoreboard for the drive link, compares host-side status frames and published commands
`timescale 1ns/1ps
`default_nettype none

`include "cdd_defs.svh"

module cdd_link_checker (
	input logic                  clk_sys,
	input logic                  reset,
	input cdd_pkg::cdd_host_rx_t host_rx,
	input cdd_pkg::cdd_host_tx_t host_tx,
	input cdd_pkg::cdd_cmd_out_t cmd
);
	import cdd_pkg::*;

	localparam int frame_bits = 8 * `CDD_FRAME_BYTES;

	cdd_frame_u            exp_stat[$];
	cdd_frame_u            exp_cmd[$];
	logic [frame_bits-1:0] seen_bits;
	logic                  comclk_prev;
	logic                  toggle_prev;
	int                    rise_cnt;
	int                    test_errors  = 0;
	int                    total_errors = 0;
	int                    tests_run    = 0;
	int                    tests_failed = 0;

	task automatic mismatch(input string sig, input logic [frame_bits-1:0] want,
			input logic [frame_bits-1:0] got);
		$display("** Error at %0t ns: %s expected %0h, actual %0h", $time, sig, want, got);
		test_errors++;
		total_errors++;
	endtask

	task automatic report_failure(input string what);
		$display("Failure at %0t ns: %s", $time, what);
		test_errors++;
		total_errors++;
	endtask

	task automatic expect_status(input cdd_frame_u frame);
		exp_stat.push_back(frame);
	endtask

	task automatic expect_cmd(input cdd_frame_u frame);
		exp_cmd.push_back(frame);
	endtask

	task automatic check_idle();
		if (host_tx.comreq_n !== 1'b1)
			mismatch("host_tx.comreq_n", 1'b1, host_tx.comreq_n);
		if (host_tx.comsync_n !== 1'b1)
			mismatch("host_tx.comsync_n", 1'b1, host_tx.comsync_n);
		if (host_tx.cdata !== 1'b0)
			mismatch("host_tx.cdata", 1'b0, host_tx.cdata);
	endtask

	task automatic end_test(input int idx, input string name);
		if (exp_stat.size() != 0)
			report_failure($sformatf("%0d status frames never reached the host", exp_stat.size()));
		if (exp_cmd.size() != 0)
			report_failure($sformatf("%0d command frames were never published", exp_cmd.size()));
		exp_stat.delete();
		exp_cmd.delete();
		tests_run++;
		if (test_errors == 0) begin
			$display("test %0d %s: ok", idx, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d errors", idx, name, test_errors);
		end
		test_errors = 0;
	endtask

	task automatic report_totals();
		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errors);
	endtask

	always @(posedge clk_sys) begin
		cdd_frame_u want;
		if (reset) begin
			comclk_prev = 1'b1;
			toggle_prev = 1'b0;
			rise_cnt    = 0;
		end else begin
			// Host takes cdata on its rising edge, lsb first, byte 0 first
			if (!comclk_prev && host_rx.comclk) begin
				// Sync low through byte 0 and request low until each byte's first rise
				if (host_tx.comsync_n !== (rise_cnt >= 8))
					mismatch("host_tx.comsync_n", rise_cnt >= 8, host_tx.comsync_n);
				if (host_tx.comreq_n !== (rise_cnt % 8 != 0))
					mismatch("host_tx.comreq_n", rise_cnt % 8 != 0, host_tx.comreq_n);
				seen_bits = {host_tx.cdata, seen_bits[frame_bits-1:1]};
				rise_cnt++;
				if (rise_cnt == frame_bits) begin
					rise_cnt = 0;
					if (exp_stat.size() == 0) begin
						report_failure("status frame shifted out with none expected");
					end else begin
						want = exp_stat.pop_front();
						if (seen_bits !== want)
							mismatch("host_tx.cdata frame", want, seen_bits);
					end
				end
			end
			if (cmd.toggle !== toggle_prev) begin
				if (exp_cmd.size() == 0) begin
					report_failure("cmd.toggle changed with no command expected");
				end else begin
					want = exp_cmd.pop_front();
					if (cmd.frame !== want)
						mismatch("cmd.frame", want, cmd.frame);
				end
			end
			comclk_prev = host_rx.comclk;
			toggle_prev = cmd.toggle;
		end
	end

endmodule

`default_nettype wire

// ==== testbench/cdd_link_properties.sv ====
// Protocol assertions for the drive link, bound onto the top level by the bind below
`timescale 1ns/1ps
`default_nettype none

module cdd_link_properties (
	input logic                  clk_sys,
	input logic                  reset,
	input cdd_pkg::cdd_host_rx_t host_rx,
	input cdd_pkg::cdd_host_tx_t host_tx,
	input cdd_pkg::cdd_cmd_out_t cmd
);
	import cdd_pkg::*;

	int   failures = 0;
	logic comclk_q;
	logic comclk_qq;

	// Two cycles of comclk history, as the link samples it
	always_ff @(posedge clk_sys) begin
		comclk_q  <= host_rx.comclk;
		comclk_qq <= comclk_q;
	end

	reset_idle: assert property (@(posedge clk_sys)
		reset |=> (host_tx.comreq_n && host_tx.comsync_n && !host_tx.cdata && !cmd.toggle))
		else begin
			failures++;
			$error("drive outputs active in the cycle after reset");
		end

	// Last rise of a frame clears cdata as well
	cdata_on_edge: assert property (@(posedge clk_sys) disable iff (reset)
		$changed(host_tx.cdata) |->
			(comclk_qq && !comclk_q) || (!comclk_qq && comclk_q && !host_tx.cdata))
		else begin
			failures++;
			$error("cdata changed without a sampled comclk falling edge");
		end

	sync_with_request: assert property (@(posedge clk_sys) disable iff (reset)
		$fell(host_tx.comsync_n) |-> $fell(host_tx.comreq_n))
		else begin
			failures++;
			$error("comsync_n fell without comreq_n");
		end

endmodule

bind cdd_link cdd_link_properties cdd_link_properties_inst (
	.clk_sys (clk_sys),
	.reset   (reset),
	.host_rx (host_rx),
	.host_tx (host_tx),
	.cmd     (cmd)
);

`default_nettype wire

// ==== testbench/tb_cdd_link.sv ====
// Testbench top for the drive link, posts status frames, plays the host and runs the test table
`timescale 1ns/1ps
`default_nettype none

`include "cdd_defs.svh"

module tb_cdd_link;
	import cdd_pkg::*;

	localparam int clk_period   = 10;
	localparam int phase_cycles = 2;
	localparam int num_tests    = 5;
	localparam int max_frames   = 8;
	// Gap, start delay and 16 comclk phases, plus polling slack
	localparam int byte_bound   = `CDD_BYTE_GAP + `CDD_START_DELAY + 16 * phase_cycles + 8;

	typedef struct {
		string           name;
		int              n_post;
		int              spacing;
		logic [7:0]      keep_mask;
		logic [3:0][7:0] codes;
	} test_row_t;

	logic         clk_sys;
	logic         reset;
	cdd_stat_in_t stat;
	cdd_host_rx_t host_rx;
	cdd_host_tx_t host_tx;
	cdd_cmd_out_t cmd;

	test_row_t    tests [num_tests];
	cdd_frame_u   posted [max_frames];
	cdd_frame_u   host_cmds [max_frames];
	logic [31:0]  lcg_state;
	logic [7:0]   count_0;
	logic [7:0]   count_1;
	logic         exp_toggle;
	logic         table_ready;

	cdd_link cdd_link_inst (
		.clk_sys (clk_sys),
		.reset   (reset),
		.stat    (stat),
		.host_rx (host_rx),
		.host_tx (host_tx),
		.cmd     (cmd)
	);

	cdd_link_checker checker_inst (
		.clk_sys (clk_sys),
		.reset   (reset),
		.host_rx (host_rx),
		.host_tx (host_tx),
		.cmd     (cmd)
	);

	always #(clk_period / 2) clk_sys = ~clk_sys;

	////////////////////
	// Helpers
	////////////////////

	function automatic logic [7:0] next_byte();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:24];
	endfunction

	function automatic cdd_frame_u random_frame();
		cdd_frame_u f;
		for (int i = 0; i < `CDD_FRAME_BYTES; i++)
			f.bytes[i] = next_byte();
		return f;
	endfunction

	function automatic int run_cycles();
		int cycles;
		cycles = 8 + 32;
		for (int t = 0; t < num_tests; t++) begin
			cycles += tests[t].n_post * tests[t].spacing + 150;
			cycles += $countones(tests[t].keep_mask) * `CDD_FRAME_BYTES * byte_bound;
		end
		return 2 * cycles;
	endfunction

	task automatic fill_tests();
		// First transaction's code in the low byte
		tests[0] = '{"reset idle", 0, 0, 8'h00, 32'h0000_0000};
		tests[1] = '{"single frame", 1, 4, 8'h01, 32'h0000_0001};
		tests[2] = '{"command bytes", 2, 8, 8'h03, 32'h0000_0612};
		tests[3] = '{"command tallies", 4, 6, 8'h0f, 32'h3306_0906};
		// Frame 4 parks and frame 5 overwrites it
		tests[4] = '{"pending overwrite", 5, 4, 8'h17, 32'h4409_0609};
	endtask

	task automatic post_status(input cdd_frame_u frame);
		stat.frame  = frame;
		stat.toggle = ~stat.toggle;
	endtask

	task automatic wait_request();
		int waited;
		waited = 0;
		while (host_tx.comreq_n && waited < 4 * byte_bound) begin
			@(negedge clk_sys);
			waited++;
		end
		if (host_tx.comreq_n)
			checker_inst.report_failure("drive never pulled comreq_n low for the next byte");
	endtask

	// Host side, one falling and one rising comclk edge per bit
	task automatic host_transaction(input cdd_frame_u command);
		for (int b = 0; b < `CDD_FRAME_BYTES; b++) begin
			wait_request();
			for (int i = 0; i < 8; i++) begin
				host_rx.comclk = 1'b0;
				host_rx.hdata  = command.bytes[b][i];
				repeat (phase_cycles) @(negedge clk_sys);
				host_rx.comclk = 1'b1;
				repeat (phase_cycles) @(negedge clk_sys);
			end
		end
	endtask

	task automatic wait_publish();
		int waited;
		waited = 0;
		while (cmd.toggle !== exp_toggle && waited < 64) begin
			@(negedge clk_sys);
			waited++;
		end
		if (cmd.toggle !== exp_toggle)
			checker_inst.report_failure("cmd.toggle did not flip after the last command byte");
	endtask

	task automatic run_test(input int t);
		int         n_xfer;
		cdd_frame_u want;
		n_xfer = $countones(tests[t].keep_mask);
		for (int i = 0; i < tests[t].n_post; i++) begin
			posted[i] = random_frame();
			if (tests[t].keep_mask[i])
				checker_inst.expect_status(posted[i]);
		end
		// Bytes 9 and 8 carry counts of commands published before this one
		for (int j = 0; j < n_xfer; j++) begin
			host_cmds[j]             = random_frame();
			host_cmds[j].fields.code = tests[t].codes[j];
			want                     = host_cmds[j];
			want.fields.tally_0      = count_0;
			want.fields.tally_1      = count_1;
			checker_inst.expect_cmd(want);
			if (tests[t].codes[j] == `CDD_TALLY_CODE_0)
				count_0++;
			if (tests[t].codes[j] == `CDD_TALLY_CODE_1)
				count_1++;
		end

		if (tests[t].n_post == 0) begin
			checker_inst.check_idle();
			repeat (64) @(negedge clk_sys);
			checker_inst.check_idle();
		end
		for (int i = 0; i < tests[t].n_post; i++) begin
			post_status(posted[i]);
			repeat (tests[t].spacing) @(negedge clk_sys);
		end
		for (int j = 0; j < n_xfer; j++) begin
			host_transaction(host_cmds[j]);
			exp_toggle = ~exp_toggle;
		end
		if (n_xfer > 0)
			wait_publish();
		repeat (4) @(negedge clk_sys);
		checker_inst.end_test(t, tests[t].name);
	endtask

	////////////////////
	// Main sequence
	////////////////////

	initial begin
		clk_sys     = 1'b0;
		reset       = 1'b1;
		stat        = '0;
		host_rx     = '{comclk: 1'b1, hdata: 1'b0};
		lcg_state   = 32'd54;
		count_0     = 8'd0;
		count_1     = 8'd0;
		exp_toggle  = 1'b0;
		table_ready = 1'b0;
		fill_tests();
		table_ready = 1'b1;

		repeat (8) @(negedge clk_sys);
		reset = 1'b0;
		@(negedge clk_sys);

		for (int t = 0; t < num_tests; t++)
			run_test(t);

		checker_inst.report_totals();
		if (checker_inst.total_errors == 0 &&
				cdd_link_inst.cdd_link_properties_inst.failures == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	// Watchdog
	initial begin
		int limit;
		wait (table_ready === 1'b1);
		limit = run_cycles();
		#(limit * clk_period);
		$display("Timeout, the run did not finish within %0d clock cycles", limit);
		$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+include
src/cdd_pkg.sv
src/cdd_status_capture.sv
src/cdd_frame_buffer.sv
src/cdd_serial_link.sv
src/cdd_link.sv
testbench/cdd_link_properties.sv
testbench/cdd_link_checker.sv
testbench/tb_cdd_link.sv
